//--- bench/rv32_execute_checks.sv
`timescale 1ns/1ps

module rv32_execute_checks
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;
(
    input logic clk, reset_, stall, flush, writeback_flush,
    input logic valid, writeback_valid, writeback_rd_write,
    input word_t pc, rs1_value, rs2_value, imm_value, writeback_rd_value,
    input reg_addr_t rs1, rs2, writeback_rd,
    input csr_addr_t csr,
    input exec_ctrl_t ctrl,
    input mem_ctrl_t mem_ctrl,

    input logic valid_out, branch_predicted_taken_out, alu_non_zero_out, rd_write_out,
    input mem_ctrl_t mem_ctrl_out,
    input branch_op_t branch_op_out,
    input reg_addr_t rd_out,
    input word_t result_out, rs2_value_out, branch_pc_out,
    input counter_t cycle_out,

    output int error_count
);
    // expected contents of the execute register
    logic e_valid, e_pred, e_non_zero, e_rd_write;
    mem_ctrl_t e_mem;
    branch_op_t e_branch_op;
    reg_addr_t e_rd;
    word_t e_result, e_rs2, e_branch_pc;

    // reference CSR state
    counter_t m_cycle, m_instret;
    word_t m_mscratch;

    // goes high once the model has seen a reset edge
    logic live = 1'b0;

    initial error_count = 0;

    task automatic mismatch(string name, counter_t expected, counter_t actual);
        error_count = error_count + 1;
        $display("Fail %s expected %0h actual %0h", name, expected, actual);
    endtask

    // newest writer wins, x0 always reads the register file
    function automatic word_t forwarded(reg_addr_t idx, word_t file_value);
        if (idx == 5'd0)
            return file_value;
        if (e_rd_write && e_rd == idx)
            return e_result;
        if (writeback_rd_write && writeback_rd == idx)
            return writeback_rd_value;
        return file_value;
    endfunction

    function automatic word_t alu_ref(alu_op_t op, logic alt, word_t a, word_t b);
        logic [4:0] sh;
        word_t sr;
        sh = b[4:0];
        sr = a >> sh;
        // sign fill for sra
        if (alt && a[31])
            sr = sr | ~(32'hffff_ffff >> sh);
        case (op)
            ALU_OP_ADD: return alt ? a - b : a + b;
            ALU_OP_SLL: return a << sh;
            ALU_OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_OP_XOR: return a ^ b;
            ALU_OP_SR: return sr;
            ALU_OP_OR: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t csr_ref(csr_addr_t addr);
        case (addr)
            CSR_MSCRATCH: return m_mscratch;
            CSR_CYCLE: return m_cycle[31:0];
            CSR_CYCLEH: return m_cycle[63:32];
            CSR_INSTRET: return m_instret[31:0];
            CSR_INSTRETH: return m_instret[63:32];
            default: return 32'd0;
        endcase
    endfunction

    always @(posedge clk) begin : model_step
        word_t fwd1;
        word_t fwd2;
        word_t a;
        word_t b;
        word_t sum;
        word_t wval;
        mem_ctrl_t mem;
        if (!reset_) begin
            live <= 1'b1;
            e_valid <= 1'b0;
            e_pred <= 1'b0;
            e_non_zero <= 1'b0;
            e_rd_write <= 1'b0;
            e_mem <= '0;
            e_branch_op <= BRANCH_OP_NEVER;
            e_rd <= '0;
            e_result <= '0;
            e_rs2 <= '0;
            e_branch_pc <= '0;
            m_cycle <= '0;
            m_instret <= '0;
            m_mscratch <= '0;
        end else begin
            fwd1 = forwarded(rs1, rs1_value);
            fwd2 = forwarded(rs2, rs2_value);
            m_cycle <= m_cycle + 64'd1;
            if (writeback_valid)
                m_instret <= m_instret + 64'd1;
            if (ctrl.csr.write && !stall && !writeback_flush && csr == CSR_MSCRATCH) begin
                wval = ctrl.csr.src ? imm_value : fwd1;
                case (ctrl.csr.write_op)
                    CSR_WRITE_OP_RS: m_mscratch <= m_mscratch | wval;
                    CSR_WRITE_OP_RC: m_mscratch <= m_mscratch & ~wval;
                    default: m_mscratch <= wval;
                endcase
            end
            if (!stall) begin
                case (ctrl.alu.src1)
                    ALU_SRC1_RS1: a = fwd1;
                    ALU_SRC1_PC: a = pc;
                    default: a = 32'd0;
                endcase
                case (ctrl.alu.src2)
                    ALU_SRC2_RS2: b = fwd2;
                    ALU_SRC2_IMM: b = imm_value;
                    default: b = 32'd4;
                endcase
                sum = alu_ref(ctrl.alu.op, ctrl.alu.sub_sra, a, b);
                e_non_zero <= sum != 32'd0;
                e_result <= ctrl.csr.read ? csr_ref(csr) : sum;
                e_rs2 <= fwd2;
                if (ctrl.branch_predicted_taken)
                    e_branch_pc <= pc + 32'd4;
                else if (ctrl.branch_pc_src)
                    e_branch_pc <= (fwd1 + imm_value) & ~32'd1;
                else
                    e_branch_pc <= pc + imm_value;
                e_rd <= ctrl.rd;
                // a flush empties the slot but keeps the data
                mem = mem_ctrl;
                if (flush) begin
                    mem.read = 1'b0;
                    mem.write = 1'b0;
                end
                e_mem <= mem;
                e_valid <= valid && !flush;
                e_rd_write <= ctrl.rd_write && !flush;
                e_pred <= ctrl.branch_predicted_taken && !flush;
                e_branch_op <= flush ? BRANCH_OP_NEVER : ctrl.branch_op;
            end
        end
    end

    // outputs only move on posedge, so the falling edge sees them settled
    a_valid: assert property (@(negedge clk) disable iff (!live) valid_out == e_valid)
        else mismatch("valid_out", 64'(e_valid), 64'(valid_out));
    a_mem: assert property (@(negedge clk) disable iff (!live) mem_ctrl_out == e_mem)
        else mismatch("mem_ctrl_out", 64'(e_mem), 64'(mem_ctrl_out));
    a_branch_op: assert property (@(negedge clk) disable iff (!live)
        branch_op_out == e_branch_op)
        else mismatch("branch_op_out", 64'(e_branch_op), 64'(branch_op_out));
    a_pred: assert property (@(negedge clk) disable iff (!live)
        branch_predicted_taken_out == e_pred)
        else mismatch("branch_predicted_taken_out", 64'(e_pred),
                      64'(branch_predicted_taken_out));
    a_non_zero: assert property (@(negedge clk) disable iff (!live)
        alu_non_zero_out == e_non_zero)
        else mismatch("alu_non_zero_out", 64'(e_non_zero), 64'(alu_non_zero_out));
    a_rd: assert property (@(negedge clk) disable iff (!live) rd_out == e_rd)
        else mismatch("rd_out", 64'(e_rd), 64'(rd_out));
    a_rd_write: assert property (@(negedge clk) disable iff (!live) rd_write_out == e_rd_write)
        else mismatch("rd_write_out", 64'(e_rd_write), 64'(rd_write_out));
    a_result: assert property (@(negedge clk) disable iff (!live) result_out == e_result)
        else mismatch("result_out", 64'(e_result), 64'(result_out));
    a_rs2: assert property (@(negedge clk) disable iff (!live) rs2_value_out == e_rs2)
        else mismatch("rs2_value_out", 64'(e_rs2), 64'(rs2_value_out));
    a_branch_pc: assert property (@(negedge clk) disable iff (!live)
        branch_pc_out == e_branch_pc)
        else mismatch("branch_pc_out", 64'(e_branch_pc), 64'(branch_pc_out));
    a_cycle: assert property (@(negedge clk) disable iff (!live) cycle_out == m_cycle)
        else mismatch("cycle_out", m_cycle, cycle_out);
endmodule

//--- bench/rv32_execute_tb.sv
`timescale 1ns/1ps

module rv32_execute_tb
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 400;

    logic clk;
    logic reset_;
    logic stall, flush, writeback_flush;
    logic valid, writeback_valid, writeback_rd_write;
    word_t pc, rs1_value, rs2_value, imm_value, writeback_rd_value;
    reg_addr_t rs1, rs2, writeback_rd;
    csr_addr_t csr;
    exec_ctrl_t ctrl;
    mem_ctrl_t mem_ctrl;

    logic valid_out, branch_predicted_taken_out, alu_non_zero_out, rd_write_out;
    mem_ctrl_t mem_ctrl_out;
    branch_op_t branch_op_out;
    reg_addr_t rd_out;
    word_t result_out, rs2_value_out, branch_pc_out;
    counter_t cycle_out;

    int error_count;
    int cycle_count = 0;
    int seed = 32'h855da302;

    csr_addr_t counter_csrs [4] = '{CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET, CSR_INSTRETH};

    rv32_execute dut_i (.*);

    rv32_execute_checks checks_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic int rand_below(int span);
        return int'($unsigned($random(seed)) % span);
    endfunction

    function automatic logic one_in(int span);
        return rand_below(span) == 0;
    endfunction

    task automatic clear_inputs();
        valid = 1'b0;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm_value = '0;
        csr = '0;
        ctrl = '0;
        mem_ctrl = '0;
        stall = 1'b0;
        flush = 1'b0;
        writeback_flush = 1'b0;
        writeback_valid = 1'b0;
        writeback_rd = '0;
        writeback_rd_write = 1'b0;
        writeback_rd_value = '0;
    endtask

    // i walks the ALU op and source selects, span bounds the register indices
    task automatic drive_item(int i, int span);
        valid = !one_in(8);
        pc = word_t'($random(seed)) & ~32'd3;
        rs1 = reg_addr_t'(rand_below(span));
        rs2 = reg_addr_t'(rand_below(span));
        rs1_value = $random(seed);
        rs2_value = $random(seed);
        imm_value = $random(seed);
        csr = CSR_MSCRATCH;
        ctrl.alu.op = alu_op_t'(i % 8);
        ctrl.alu.sub_sra = i[3];
        ctrl.alu.src1 = alu_src1_t'(i % 3);
        ctrl.alu.src2 = alu_src2_t'((i / 3) % 3);
        ctrl.csr = '0;
        ctrl.branch_op = branch_op_t'(rand_below(4));
        ctrl.branch_pc_src = one_in(2);
        ctrl.branch_predicted_taken = one_in(3);
        ctrl.rd = reg_addr_t'(rand_below(span));
        ctrl.rd_write = !one_in(4);
        // loads and stores never share a slot
        mem_ctrl.read = one_in(2);
        mem_ctrl.write = !mem_ctrl.read && one_in(2);
        mem_ctrl.width = mem_width_t'(rand_below(3));
        mem_ctrl.zero_extend = one_in(2);
        mem_ctrl.fence = one_in(4);
        writeback_valid = one_in(2);
        writeback_rd = reg_addr_t'(rand_below(span));
        writeback_rd_write = one_in(2);
        writeback_rd_value = $random(seed);
        stall = 1'b0;
        flush = 1'b0;
        writeback_flush = 1'b0;
    endtask

    initial begin
        reset_ = 1'b0;
        clear_inputs();
        repeat (10) @(negedge clk);
        reset_ = 1'b1;

        // empty register right after reset
        repeat (2) @(negedge clk);

        for (int i = 0; i < 60; i++) begin
            drive_item(i, 32);
            @(negedge clk);
        end

        // few registers so back-to-back items depend on each other
        for (int i = 0; i < 24; i++) begin
            drive_item(i, 4);
            @(negedge clk);
        end

        for (int i = 0; i < 30; i++) begin
            drive_item(i, 4);
            stall = one_in(4);
            flush = one_in(4);
            @(negedge clk);
        end

        for (int i = 0; i < 8; i++) begin
            drive_item(i, 4);
            ctrl.csr.read = 1'b1;
            csr = counter_csrs[i % 4];
            @(negedge clk);
        end

        // mscratch updates, some blocked, some aimed at a counter
        for (int i = 0; i < 30; i++) begin
            drive_item(i, 4);
            csr = one_in(5) ? CSR_CYCLE : CSR_MSCRATCH;
            ctrl.csr.read = one_in(2);
            ctrl.csr.write = 1'b1;
            ctrl.csr.write_op = csr_write_op_t'(i % 3);
            ctrl.csr.src = one_in(2);
            stall = one_in(5);
            writeback_flush = one_in(5);
            @(negedge clk);
        end

        drive_item(0, 4);
        ctrl.csr.read = 1'b1;
        @(negedge clk);

        clear_inputs();
        repeat (2) @(negedge clk);
        @(posedge clk);

        $display("checks done, errors: %0d", error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end
endmodule

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv32_execute_tb -Mdir obj_dir -f rv32_execute.f

# the verdict comes from the printed result, not the exit status
out=$(./obj_dir/Vrv32_execute_tb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Test completed successfully'; then
    exit 0
fi
exit 1

//--- rv32_execute.f
src/rv32_types_pkg.sv
src/rv32_ctrl_pkg.sv
src/rv32_alu.sv
src/rv32_csrs.sv
src/rv32_execute.sv
bench/rv32_execute_checks.sv
bench/rv32_execute_tb.sv

//--- src/rv32_alu.sv
`timescale 1ns/1ps

module rv32_alu
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;
(
    input alu_op_t op,
    input logic sub_sra,
    input alu_src1_t src1,
    input alu_src2_t src2,

    input word_t pc,
    input word_t rs1_value,
    input word_t rs2_value,
    input word_t imm_value,

    output logic non_zero,
    output word_t result
);
    word_t a;
    word_t b;
    logic [4:0] shamt;

    // operand selection
    always_comb begin
        case (src1)
            ALU_SRC1_RS1: a = rs1_value;
            ALU_SRC1_PC: a = pc;
            default: a = '0;
        endcase

        case (src2)
            ALU_SRC2_RS2: b = rs2_value;
            ALU_SRC2_IMM: b = imm_value;
            default: b = 32'd4;
        endcase
    end

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_OP_ADD: result = sub_sra ? a - b : a + b;
            ALU_OP_SLL: result = a << shamt;
            ALU_OP_SLT: result = {31'b0, $signed(a) < $signed(b)};
            ALU_OP_SLTU: result = {31'b0, a < b};
            ALU_OP_XOR: result = a ^ b;
            ALU_OP_SR: begin
                if (sub_sra)
                    result = word_t'($signed(a) >>> shamt);
                else
                    result = a >> shamt;
            end
            ALU_OP_OR: result = a | b;
            default: result = a & b;
        endcase
    end

    // branches resolve on this in the memory stage
    assign non_zero = |result;

    // decode must never hand over the spare select encodings
    always_comb begin
        if (!$isunknown({src1, src2})) begin
            assert (src1 inside {ALU_SRC1_RS1, ALU_SRC1_PC, ALU_SRC1_ZERO} &&
                    src2 inside {ALU_SRC2_RS2, ALU_SRC2_IMM, ALU_SRC2_FOUR})
            else
                $error("alu operand select undefined: src1=%0h src2=%0h", src1, src2);
        end
    end
endmodule

//--- src/rv32_csrs.sv
`timescale 1ns/1ps

module rv32_csrs
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;
(
    input logic clk,
    input logic reset_,
    input logic stall,
    input logic writeback_flush,

    input logic read,
    input logic write,
    input csr_write_op_t write_op,
    input logic src,

    input logic instr_retired,

    input word_t rs1_value,
    input word_t imm_value,
    input csr_addr_t csr,

    output word_t read_value,
    output counter_t cycle_out
);
    counter_t cycle;
    counter_t instret;
    word_t mscratch;

    word_t write_value;
    word_t mscratch_next;
    logic mscratch_write;

    // only mscratch is writable, counter writes fall through
    assign write_value = src ? imm_value : rs1_value;
    assign mscratch_write = write && !stall && !writeback_flush && csr == CSR_MSCRATCH;

    always_comb begin
        case (write_op)
            CSR_WRITE_OP_RS: mscratch_next = mscratch | write_value;
            CSR_WRITE_OP_RC: mscratch_next = mscratch & ~write_value;
            default: mscratch_next = write_value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            cycle <= '0;
            instret <= '0;
            mscratch <= '0;
        end else begin
            // cycle keeps counting through stalls
            cycle <= cycle + 64'd1;

            if (instr_retired)
                instret <= instret + 64'd1;

            if (mscratch_write)
                mscratch <= mscratch_next;
        end
    end

    always_comb begin
        read_value = '0;
        if (read) begin
            case (csr)
                CSR_MSCRATCH: read_value = mscratch;
                CSR_CYCLE: read_value = cycle[31:0];
                CSR_CYCLEH: read_value = cycle[63:32];
                CSR_INSTRET: read_value = instret[31:0];
                CSR_INSTRETH: read_value = instret[63:32];
                default: read_value = '0;
            endcase
        end
    end

    assign cycle_out = cycle;

    a_cycle_step: assert property (@(posedge clk) disable iff (!reset_)
        $past(reset_) |-> cycle == $past(cycle) + 64'd1);

    a_mscratch_stall_hold: assert property (@(posedge clk) disable iff (!reset_)
        stall |=> mscratch == $past(mscratch));
endmodule

//--- src/rv32_ctrl_pkg.sv
package rv32_ctrl_pkg;

    import rv32_types_pkg::*;

    // op codes follow funct3, sub_sra picks sub and sra
    typedef enum logic [2:0] {
        ALU_OP_ADD = 3'b000,
        ALU_OP_SLL = 3'b001,
        ALU_OP_SLT = 3'b010,
        ALU_OP_SLTU = 3'b011,
        ALU_OP_XOR = 3'b100,
        ALU_OP_SR = 3'b101,
        ALU_OP_OR = 3'b110,
        ALU_OP_AND = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_SRC1_RS1 = 2'b00,
        ALU_SRC1_PC = 2'b01,
        ALU_SRC1_ZERO = 2'b10
    } alu_src1_t;

    typedef enum logic [1:0] {
        ALU_SRC2_RS2 = 2'b00,
        ALU_SRC2_IMM = 2'b01,
        ALU_SRC2_FOUR = 2'b10
    } alu_src2_t;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE = 2'b00,
        MEM_WIDTH_HALF = 2'b01,
        MEM_WIDTH_WORD = 2'b10
    } mem_width_t;

    typedef enum logic [1:0] {
        CSR_WRITE_OP_RW = 2'b00,
        CSR_WRITE_OP_RS = 2'b01,
        CSR_WRITE_OP_RC = 2'b10
    } csr_write_op_t;

    // never must stay zero, reset relies on it
    typedef enum logic [1:0] {
        BRANCH_OP_NEVER = 2'b00,
        BRANCH_OP_ZERO = 2'b01,
        BRANCH_OP_NON_ZERO = 2'b10,
        BRANCH_OP_ALWAYS = 2'b11
    } branch_op_t;

    typedef struct packed {
        alu_op_t op;
        logic sub_sra;
        alu_src1_t src1;
        alu_src2_t src2;
    } alu_ctrl_t;

    // src is 0 for rs1, 1 for the zero-extended immediate
    typedef struct packed {
        logic read;
        logic write;
        csr_write_op_t write_op;
        logic src;
    } csr_ctrl_t;

    // branch_pc_src is 0 for pc-relative, 1 for rs1-relative
    typedef struct packed {
        alu_ctrl_t alu;
        csr_ctrl_t csr;
        branch_op_t branch_op;
        logic branch_pc_src;
        logic branch_predicted_taken;
        reg_addr_t rd;
        logic rd_write;
    } exec_ctrl_t;

    typedef struct packed {
        logic read;
        logic write;
        mem_width_t width;
        logic zero_extend;
        logic fence;
    } mem_ctrl_t;

endpackage

//--- src/rv32_execute.sv
`timescale 1ns/1ps

module rv32_execute
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;
(
    input logic clk,
    input logic reset_,

    // hazard unit
    input logic stall,
    input logic flush,
    input logic writeback_flush,

    // decode
    input logic valid,
    input word_t pc,
    input reg_addr_t rs1,
    input reg_addr_t rs2,
    input word_t rs1_value,
    input word_t rs2_value,
    input word_t imm_value,
    input csr_addr_t csr,
    input exec_ctrl_t ctrl,
    input mem_ctrl_t mem_ctrl,

    // writeback
    input logic writeback_valid,
    input reg_addr_t writeback_rd,
    input logic writeback_rd_write,
    input word_t writeback_rd_value,

    output logic valid_out,
    output mem_ctrl_t mem_ctrl_out,
    output branch_op_t branch_op_out,
    output logic branch_predicted_taken_out,
    output logic alu_non_zero_out,
    output reg_addr_t rd_out,
    output logic rd_write_out,
    output word_t result_out,
    output word_t rs2_value_out,
    output word_t branch_pc_out,

    // to the timer
    output counter_t cycle_out
);
    word_t rs1_fwd;
    word_t rs2_fwd;
    logic alu_non_zero;
    word_t alu_result;
    word_t csr_read_value;
    word_t result;
    word_t target_base;
    word_t target;
    word_t branch_pc;

    // the item in the execute register is younger than writeback, so it wins
    function automatic word_t bypass(reg_addr_t src, word_t reg_value);
        if (src == '0)
            return reg_value;
        else if (rd_write_out && rd_out == src)
            return result_out;
        else if (writeback_rd_write && writeback_rd == src)
            return writeback_rd_value;
        else
            return reg_value;
    endfunction

    always_comb begin
        rs1_fwd = bypass(rs1, rs1_value);
        rs2_fwd = bypass(rs2, rs2_value);
    end

    rv32_alu alu_i (
        .op(ctrl.alu.op),
        .sub_sra(ctrl.alu.sub_sra),
        .src1(ctrl.alu.src1),
        .src2(ctrl.alu.src2),
        .pc(pc),
        .rs1_value(rs1_fwd),
        .rs2_value(rs2_fwd),
        .imm_value(imm_value),
        .non_zero(alu_non_zero),
        .result(alu_result)
    );

    rv32_csrs csrs_i (
        .clk(clk),
        .reset_(reset_),
        .stall(stall),
        .writeback_flush(writeback_flush),
        .read(ctrl.csr.read),
        .write(ctrl.csr.write),
        .write_op(ctrl.csr.write_op),
        .src(ctrl.csr.src),
        .instr_retired(writeback_valid),
        .rs1_value(rs1_fwd),
        .imm_value(imm_value),
        .csr(csr),
        .read_value(csr_read_value),
        .cycle_out(cycle_out)
    );

    // jalr targets drop bit 0
    assign target_base = ctrl.branch_pc_src ? rs1_fwd : pc;
    assign target = target_base + imm_value;

    // a predicted-taken branch carries the fall-through pc for correction
    assign branch_pc = ctrl.branch_predicted_taken ? pc + 32'd4
                     : {target[31:1], target[0] & !ctrl.branch_pc_src};

    assign result = ctrl.csr.read ? csr_read_value : alu_result;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            valid_out <= 1'b0;
            mem_ctrl_out <= '0;
            branch_op_out <= BRANCH_OP_NEVER;
            branch_predicted_taken_out <= 1'b0;
            alu_non_zero_out <= 1'b0;
            rd_out <= '0;
            rd_write_out <= 1'b0;
            result_out <= '0;
            rs2_value_out <= '0;
            branch_pc_out <= '0;
        end else if (!stall) begin
            valid_out <= valid;
            mem_ctrl_out <= mem_ctrl;
            branch_op_out <= ctrl.branch_op;
            branch_predicted_taken_out <= ctrl.branch_predicted_taken;
            alu_non_zero_out <= alu_non_zero;
            rd_out <= ctrl.rd;
            rd_write_out <= ctrl.rd_write;
            result_out <= result;
            rs2_value_out <= rs2_fwd;
            branch_pc_out <= branch_pc;

            // empty slot, data fields still load
            if (flush) begin
                valid_out <= 1'b0;
                mem_ctrl_out.read <= 1'b0;
                mem_ctrl_out.write <= 1'b0;
                branch_op_out <= BRANCH_OP_NEVER;
                branch_predicted_taken_out <= 1'b0;
                rd_write_out <= 1'b0;
            end
        end
    end

    a_flush_empty: assert property (@(posedge clk) disable iff (!reset_)
        flush && !stall |=> !valid_out);

    a_stall_hold: assert property (@(posedge clk) disable iff (!reset_)
        stall |=> $stable(result_out));

    a_mem_rw_exclusive: assert property (@(posedge clk) disable iff (!reset_)
        !(mem_ctrl_out.read && mem_ctrl_out.write));
endmodule

//--- src/rv32_types_pkg.sv
package rv32_types_pkg;

    // one architectural register value, data word or pc
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    typedef logic [11:0] csr_addr_t;

    // full width of the cycle and instret counters
    typedef logic [63:0] counter_t;

    // machine scratch register
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;

    // user-level read-only counter views
    localparam csr_addr_t CSR_CYCLE = 12'hc00;
    localparam csr_addr_t CSR_INSTRET = 12'hc02;
    localparam csr_addr_t CSR_CYCLEH = 12'hc80;
    localparam csr_addr_t CSR_INSTRETH = 12'hc82;

endpackage
